//--- rtl/soc_pkg.sv
// shared definitions for the peripheral subsystem
// address map, register offsets, bus widths and interrupt bit positions
`default_nettype none

package soc_pkg;

  typedef logic [31:0] addr_t;  // nmi byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;  // nonzero means a write
  typedef logic [7:0]  irq_t;
  typedef logic [11:0] ofs_t;   // byte offset inside one device window

  typedef enum logic [2:0] {DEV_RAM, DEV_GPIO, DEV_TIMER, DEV_APB, DEV_NONE} dev_sel_t;

  typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS, APB_DONE} apb_state_t;

  ////////////////////////////////////////////////////////////
  // address map, the decoder only looks at bits 31:28 and 15:12
  localparam addr_t RAM_BASE   = 32'h0000_0000;
  localparam addr_t GPIO_BASE  = 32'h1000_0000;
  localparam addr_t TIMER_BASE = 32'h1000_1000;
  localparam addr_t APB_BASE   = 32'h2000_0000;

  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = 8;   // word address width
  localparam int GPIO_W    = 8;

  ////////////////////////////////////////////////////////////
  // register offsets
  localparam ofs_t GPIO_OUT   = 12'h000;
  localparam ofs_t GPIO_IN    = 12'h004;
  localparam ofs_t GPIO_OEN   = 12'h008;
  localparam ofs_t GPIO_IEN   = 12'h00C;
  localparam ofs_t GPIO_IPEND = 12'h010;  // write 1 to clear

  localparam ofs_t TMR_COUNT = 12'h000;
  localparam ofs_t TMR_CMP   = 12'h004;
  localparam ofs_t TMR_CTRL  = 12'h008;  // bit 0 enables counting
  localparam ofs_t TMR_STAT  = 12'h00C;

  localparam ofs_t PWM_PERIOD = 12'h000;
  localparam ofs_t PWM_DUTY   = 12'h004;
  localparam ofs_t PWM_CTRL   = 12'h008;

  // interrupt vector positions, remaining bits stay zero
  localparam int IRQ_EXT   = 0;
  localparam int IRQ_TIMER = 1;
  localparam int IRQ_GPIO  = 2;

endpackage

`default_nettype wire

//--- rtl/nmi_bus.sv
// nmi address decoder
// routes a request to ram, gpio, timer or apb and returns the selected response
`timescale 1ns/1ps
`default_nettype none

module nmi_bus (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           mem_valid_i,
  input  soc_pkg::addr_t mem_addr_i,
  input  logic           ram_ready_i,
  input  soc_pkg::data_t ram_rdata_i,
  input  logic           gpio_ready_i,
  input  soc_pkg::data_t gpio_rdata_i,
  input  logic           timer_ready_i,
  input  soc_pkg::data_t timer_rdata_i,
  input  logic           apb_ready_i,
  input  soc_pkg::data_t apb_rdata_i,
  output logic           ram_sel_o,
  output logic           gpio_sel_o,
  output logic           timer_sel_o,
  output logic           apb_sel_o,
  output logic           mem_ready_o,
  output soc_pkg::data_t mem_rdata_o
);

  soc_pkg::dev_sel_t dev_sel;
  logic              none_ready_q;  // response for unmapped addresses

  function automatic logic [7:0] dec_key(input soc_pkg::addr_t addr);
    return {addr[31:28], addr[15:12]};
  endfunction

  always_comb begin
    if (dec_key(mem_addr_i) == dec_key(soc_pkg::RAM_BASE))
      dev_sel = soc_pkg::DEV_RAM;
    else if (dec_key(mem_addr_i) == dec_key(soc_pkg::GPIO_BASE))
      dev_sel = soc_pkg::DEV_GPIO;
    else if (dec_key(mem_addr_i) == dec_key(soc_pkg::TIMER_BASE))
      dev_sel = soc_pkg::DEV_TIMER;
    else if (dec_key(mem_addr_i) == dec_key(soc_pkg::APB_BASE))
      dev_sel = soc_pkg::DEV_APB;
    else
      dev_sel = soc_pkg::DEV_NONE;
  end

  assign ram_sel_o   = mem_valid_i & (dev_sel == soc_pkg::DEV_RAM);
  assign gpio_sel_o  = mem_valid_i & (dev_sel == soc_pkg::DEV_GPIO);
  assign timer_sel_o = mem_valid_i & (dev_sel == soc_pkg::DEV_TIMER);
  assign apb_sel_o   = mem_valid_i & (dev_sel == soc_pkg::DEV_APB);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      none_ready_q <= 1'b0;
    end else begin
      none_ready_q <= mem_valid_i & (dev_sel == soc_pkg::DEV_NONE) & ~none_ready_q;
    end
  end

  always_comb begin
    case (dev_sel)
      soc_pkg::DEV_RAM:   {mem_ready_o, mem_rdata_o} = {ram_ready_i, ram_rdata_i};
      soc_pkg::DEV_GPIO:  {mem_ready_o, mem_rdata_o} = {gpio_ready_i, gpio_rdata_i};
      soc_pkg::DEV_TIMER: {mem_ready_o, mem_rdata_o} = {timer_ready_i, timer_rdata_i};
      soc_pkg::DEV_APB:   {mem_ready_o, mem_rdata_o} = {apb_ready_i, apb_rdata_i};
      default:            {mem_ready_o, mem_rdata_o} = {none_ready_q, 32'h0};  // reads as zero
    endcase
  end

  // a device may only answer while the master still holds its request
  a_one_sel: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({ram_sel_o, gpio_sel_o, timer_sel_o, apb_sel_o}));
  a_ready_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_ready_o |-> mem_valid_i);

endmodule

`default_nettype wire

//--- rtl/natv_ram.sv
// on-chip word ram on the native bus
`timescale 1ns/1ps
`default_nettype none

module natv_ram (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           sel_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output logic           ready_o,
  output soc_pkg::data_t rdata_o
);

  soc_pkg::data_t              mem [soc_pkg::RAM_WORDS];
  soc_pkg::data_t              rdata_q;
  logic [soc_pkg::RAM_AW-1:0]  idx;
  logic                        ready_q;
  logic                        acc;  // first cycle of a request

  assign idx = addr_i[soc_pkg::RAM_AW+1:2];
  assign acc = sel_i & ~ready_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) ready_q <= 1'b0;
    else       ready_q <= acc;
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      for (int i = 0; i < 4; i++) begin
        if (wstrb_i[i]) mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];  // only enabled lanes
      end
      rdata_q <= mem[idx];
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- rtl/natv_gpio.sv
// gpio block with output, enable and rising-edge interrupt registers
`timescale 1ns/1ps
`default_nettype none

module natv_gpio (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       sel_i,
  input  soc_pkg::addr_t             addr_i,
  input  soc_pkg::data_t             wdata_i,
  input  soc_pkg::strb_t             wstrb_i,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  output logic                       ready_o,
  output soc_pkg::data_t             rdata_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_oen_o,
  output logic                       irq_o
);

  logic [soc_pkg::GPIO_W-1:0] out_q, oen_q;
  logic [soc_pkg::GPIO_W-1:0] ien_q, pend_q;
  logic [soc_pkg::GPIO_W-1:0] sync1_q, sync2_q, prev_q;
  logic [soc_pkg::GPIO_W-1:0] rise, clr;
  soc_pkg::ofs_t              ofs;
  soc_pkg::data_t             rdata_q;
  logic                       ready_q, acc, wr;

  assign ofs  = addr_i[11:0];
  assign acc  = sel_i & ~ready_q;
  assign wr   = acc & (|wstrb_i);  // any strobe writes the whole word
  assign rise = sync2_q & ~prev_q;
  assign clr  = (wr && ofs == soc_pkg::GPIO_IPEND) ? wdata_i[soc_pkg::GPIO_W-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
      out_q   <= '0;
      oen_q   <= '0;
      ien_q   <= '0;
      pend_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      ready_q <= acc;
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && ofs == soc_pkg::GPIO_OUT) out_q <= wdata_i[soc_pkg::GPIO_W-1:0];
      if (wr && ofs == soc_pkg::GPIO_OEN) oen_q <= wdata_i[soc_pkg::GPIO_W-1:0];
      if (wr && ofs == soc_pkg::GPIO_IEN) ien_q <= wdata_i[soc_pkg::GPIO_W-1:0];
      // a new edge wins over a clear in the same cycle
      pend_q <= (pend_q & ~clr) | (rise & ien_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      case (ofs)
        soc_pkg::GPIO_OUT:   rdata_q <= soc_pkg::data_t'(out_q);
        soc_pkg::GPIO_IN:    rdata_q <= soc_pkg::data_t'(sync2_q);
        soc_pkg::GPIO_OEN:   rdata_q <= soc_pkg::data_t'(oen_q);
        soc_pkg::GPIO_IEN:   rdata_q <= soc_pkg::data_t'(ien_q);
        soc_pkg::GPIO_IPEND: rdata_q <= soc_pkg::data_t'(pend_q);
        default:             rdata_q <= '0;
      endcase
    end
  end

  assign ready_o    = ready_q;
  assign rdata_o    = rdata_q;
  assign gpio_out_o = out_q;
  assign gpio_oen_o = oen_q;
  assign irq_o      = |pend_q;

endmodule

`default_nettype wire

//--- rtl/natv_timer.sv
// free-running compare timer with a sticky match interrupt
`timescale 1ns/1ps
`default_nettype none

module natv_timer (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           sel_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  output logic           ready_o,
  output soc_pkg::data_t rdata_o,
  output logic           irq_o
);

  soc_pkg::data_t count_q, cmp_q;
  soc_pkg::data_t rdata_q;
  soc_pkg::ofs_t  ofs;
  logic           en_q, stat_q;
  logic           ready_q, acc, wr;
  logic           match;

  assign ofs   = addr_i[11:0];
  assign acc   = sel_i & ~ready_q;
  assign wr    = acc & (|wstrb_i);
  assign match = en_q & (count_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
      en_q    <= 1'b0;
      stat_q  <= 1'b0;
    end else begin
      ready_q <= acc;
      // a bus write to the count takes priority over counting
      if (wr && ofs == soc_pkg::TMR_COUNT) count_q <= wdata_i;
      else if (match)                      count_q <= '0;
      else if (en_q)                       count_q <= count_q + 32'd1;
      if (wr && ofs == soc_pkg::TMR_CMP)  cmp_q <= wdata_i;
      if (wr && ofs == soc_pkg::TMR_CTRL) en_q  <= wdata_i[0];
      stat_q <= match | (stat_q & ~(wr && ofs == soc_pkg::TMR_STAT && wdata_i[0]));
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc) begin
      case (ofs)
        soc_pkg::TMR_COUNT: rdata_q <= count_q;
        soc_pkg::TMR_CMP:   rdata_q <= cmp_q;
        soc_pkg::TMR_CTRL:  rdata_q <= {31'h0, en_q};
        soc_pkg::TMR_STAT:  rdata_q <= {31'h0, stat_q};
        default:            rdata_q <= '0;
      endcase
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;
  assign irq_o   = stat_q;  // level stays up until software clears it

  a_count_le_cmp: assert property (@(posedge clk_i) disable iff (rst_i)
    en_q |-> count_q <= cmp_q);

endmodule

`default_nettype wire

//--- rtl/apb_bridge.sv
// nmi to apb bridge
// turns one nmi request into an apb setup and access phase
`timescale 1ns/1ps
`default_nettype none

module apb_bridge (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           sel_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t wstrb_i,
  input  soc_pkg::data_t prdata_i,
  input  logic           pready_i,
  output logic           ready_o,
  output soc_pkg::data_t rdata_o,
  output logic           psel_o,
  output logic           penable_o,
  output logic           pwrite_o,
  output soc_pkg::ofs_t  paddr_o,
  output soc_pkg::data_t pwdata_o
);

  soc_pkg::apb_state_t state_q;
  soc_pkg::ofs_t       addr_q;
  soc_pkg::data_t      wdata_q, rdata_q;
  logic                write_q;

  ////////////////////////////////////////////////////////////
  // IDLE -> SETUP -> ACCESS -> DONE -> IDLE
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= soc_pkg::APB_IDLE;
      write_q <= 1'b0;
    end else begin
      case (state_q)
        soc_pkg::APB_IDLE: if (sel_i) begin
          state_q <= soc_pkg::APB_SETUP;
          write_q <= |wstrb_i;
        end
        soc_pkg::APB_SETUP:  state_q <= soc_pkg::APB_ACCESS;
        soc_pkg::APB_ACCESS: if (pready_i) state_q <= soc_pkg::APB_DONE;  // slave may stretch
        default:             state_q <= soc_pkg::APB_IDLE;
      endcase
    end
  end

  // request is held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (state_q == soc_pkg::APB_IDLE && sel_i) begin
      addr_q  <= addr_i[11:0];
      wdata_q <= wdata_i;
    end
    if (state_q == soc_pkg::APB_ACCESS && pready_i) rdata_q <= prdata_i;
  end

  assign psel_o    = (state_q == soc_pkg::APB_SETUP) | (state_q == soc_pkg::APB_ACCESS);
  assign penable_o = (state_q == soc_pkg::APB_ACCESS);
  assign pwrite_o  = write_q;
  assign paddr_o   = addr_q;
  assign pwdata_o  = wdata_q;
  assign ready_o   = (state_q == soc_pkg::APB_DONE);
  assign rdata_o   = rdata_q;

  // the access phase only happens inside a selected transfer
  a_pen_psel: assert property (@(posedge clk_i) disable iff (rst_i)
    penable_o |-> psel_o);

endmodule

`default_nettype wire

//--- rtl/apb_pwm.sv
// apb pwm generator with period, duty and enable registers
`timescale 1ns/1ps
`default_nettype none

module apb_pwm (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  soc_pkg::ofs_t  paddr_i,
  input  soc_pkg::data_t pwdata_i,
  output soc_pkg::data_t prdata_o,
  output logic           pready_o,
  output logic           pwm_o
);

  soc_pkg::data_t period_q, duty_q;
  soc_pkg::data_t cnt_q;
  logic           en_q, pwm_q;
  logic           wr;

  assign wr       = psel_i & penable_i & pwrite_i;
  assign pready_o = 1'b1;  // no wait states

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      period_q <= '0;
      duty_q   <= '0;
      en_q     <= 1'b0;
      cnt_q    <= '0;
      pwm_q    <= 1'b0;
    end else begin
      if (wr && paddr_i == soc_pkg::PWM_PERIOD) period_q <= pwdata_i;
      if (wr && paddr_i == soc_pkg::PWM_DUTY)   duty_q   <= pwdata_i;
      if (wr && paddr_i == soc_pkg::PWM_CTRL)   en_q     <= pwdata_i[0];
      if (!en_q) begin
        cnt_q <= '0;
        pwm_q <= 1'b0;
      end else begin
        // wraps after period-1, a zero period keeps the counter at 0
        if (cnt_q + 32'd1 >= period_q) cnt_q <= '0;
        else                           cnt_q <= cnt_q + 32'd1;
        pwm_q <= (cnt_q < duty_q);
      end
    end
  end

  always_comb begin
    case (paddr_i)
      soc_pkg::PWM_PERIOD: prdata_o = period_q;
      soc_pkg::PWM_DUTY:   prdata_o = duty_q;
      soc_pkg::PWM_CTRL:   prdata_o = {31'h0, en_q};
      default:             prdata_o = '0;
    endcase
  end

  assign pwm_o = pwm_q;

endmodule

`default_nettype wire

//--- rtl/periph_subsys.sv
// peripheral subsystem top
// nmi bus with ram, gpio, timer and an apb pwm, plus the interrupt vector
`timescale 1ns/1ps
`default_nettype none

module periph_subsys (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       mem_valid_i,
  input  soc_pkg::addr_t             mem_addr_i,
  input  soc_pkg::data_t             mem_wdata_i,
  input  soc_pkg::strb_t             mem_wstrb_i,
  input  logic [soc_pkg::GPIO_W-1:0] gpio_in_i,
  input  logic                       irq_pin_i,
  output logic                       mem_ready_o,
  output soc_pkg::data_t             mem_rdata_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_out_o,
  output logic [soc_pkg::GPIO_W-1:0] gpio_oen_o,
  output logic                       pwm_o,
  output soc_pkg::irq_t              irq_o
);

  logic           s_ram_sel, s_gpio_sel, s_timer_sel, s_apb_sel;
  logic           s_ram_ready, s_gpio_ready, s_timer_ready, s_apb_ready;
  soc_pkg::data_t s_ram_rdata, s_gpio_rdata, s_timer_rdata, s_apb_rdata;
  logic           s_gpio_irq, s_timer_irq;
  // apb
  logic           s_psel, s_penable, s_pwrite, s_pready;
  soc_pkg::ofs_t  s_paddr;
  soc_pkg::data_t s_pwdata, s_prdata;

  always_comb begin
    irq_o                     = '0;
    irq_o[soc_pkg::IRQ_EXT]   = irq_pin_i;
    irq_o[soc_pkg::IRQ_TIMER] = s_timer_irq;
    irq_o[soc_pkg::IRQ_GPIO]  = s_gpio_irq;
  end

  nmi_bus u_bus (
    .clk_i(clk_i), .rst_i(rst_i), .mem_valid_i(mem_valid_i), .mem_addr_i(mem_addr_i),
    .ram_ready_i(s_ram_ready), .ram_rdata_i(s_ram_rdata),
    .gpio_ready_i(s_gpio_ready), .gpio_rdata_i(s_gpio_rdata),
    .timer_ready_i(s_timer_ready), .timer_rdata_i(s_timer_rdata),
    .apb_ready_i(s_apb_ready), .apb_rdata_i(s_apb_rdata),
    .ram_sel_o(s_ram_sel), .gpio_sel_o(s_gpio_sel), .timer_sel_o(s_timer_sel),
    .apb_sel_o(s_apb_sel), .mem_ready_o(mem_ready_o), .mem_rdata_o(mem_rdata_o)
  );

  natv_ram u_ram (
    .clk_i(clk_i), .rst_i(rst_i), .sel_i(s_ram_sel), .addr_i(mem_addr_i),
    .wdata_i(mem_wdata_i), .wstrb_i(mem_wstrb_i),
    .ready_o(s_ram_ready), .rdata_o(s_ram_rdata)
  );

  natv_gpio u_gpio (
    .clk_i(clk_i), .rst_i(rst_i), .sel_i(s_gpio_sel), .addr_i(mem_addr_i),
    .wdata_i(mem_wdata_i), .wstrb_i(mem_wstrb_i), .gpio_in_i(gpio_in_i),
    .ready_o(s_gpio_ready), .rdata_o(s_gpio_rdata), .gpio_out_o(gpio_out_o),
    .gpio_oen_o(gpio_oen_o), .irq_o(s_gpio_irq)
  );

  natv_timer u_timer (
    .clk_i(clk_i), .rst_i(rst_i), .sel_i(s_timer_sel), .addr_i(mem_addr_i),
    .wdata_i(mem_wdata_i), .wstrb_i(mem_wstrb_i),
    .ready_o(s_timer_ready), .rdata_o(s_timer_rdata), .irq_o(s_timer_irq)
  );

  apb_bridge u_apb_bridge (
    .clk_i(clk_i), .rst_i(rst_i), .sel_i(s_apb_sel), .addr_i(mem_addr_i),
    .wdata_i(mem_wdata_i), .wstrb_i(mem_wstrb_i), .prdata_i(s_prdata),
    .pready_i(s_pready), .ready_o(s_apb_ready), .rdata_o(s_apb_rdata),
    .psel_o(s_psel), .penable_o(s_penable), .pwrite_o(s_pwrite),
    .paddr_o(s_paddr), .pwdata_o(s_pwdata)
  );

  apb_pwm u_pwm (
    .clk_i(clk_i), .rst_i(rst_i), .psel_i(s_psel), .penable_i(s_penable),
    .pwrite_i(s_pwrite), .paddr_i(s_paddr), .pwdata_i(s_pwdata),
    .prdata_o(s_prdata), .pready_o(s_pready), .pwm_o(pwm_o)
  );

endmodule

`default_nettype wire

//--- test/tb_periph_subsys.sv
// testbench for the peripheral subsystem
// acts as the cpu on the nmi bus and checks ram, gpio, timer, pwm and the interrupt vector
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsys;

  localparam int TAB_N      = 14;
  localparam int RAND_N     = 64;
  localparam int RAM_WIN    = 16;   // words used by the random ram test
  localparam int RAND_WORD0 = 32;   // first word of that window
  localparam int PWM_PER    = 10;
  localparam int PWM_DTY    = 3;
  // a random round is one write and one read
  localparam int CYCLE_LIMIT = TAB_N * 8 + RAND_N * 2 * 4 + 3 * PWM_PER + 200;

  logic                       clk_i, rst_i;
  logic                       mem_valid_i;
  soc_pkg::addr_t             mem_addr_i;
  soc_pkg::data_t             mem_wdata_i;
  soc_pkg::strb_t             mem_wstrb_i;
  logic [soc_pkg::GPIO_W-1:0] gpio_in_i;
  logic                       irq_pin_i;
  logic                       mem_ready_o;
  soc_pkg::data_t             mem_rdata_o;
  logic [soc_pkg::GPIO_W-1:0] gpio_out_o, gpio_oen_o;
  logic                       pwm_o;
  soc_pkg::irq_t              irq_o;

  // stimulus table, one bus register per row
  string          tab_name  [TAB_N];
  soc_pkg::addr_t tab_addr  [TAB_N];
  soc_pkg::strb_t tab_strb  [TAB_N];
  soc_pkg::data_t tab_wdata [TAB_N];
  soc_pkg::data_t tab_exp   [TAB_N];

  soc_pkg::data_t ram_model [RAM_WIN];
  soc_pkg::data_t rd, cnt, wd;
  soc_pkg::strb_t strb;
  integer         seed;
  int             err_cnt, chk_cnt, lat, k, w, high_cnt;
  int             cycle_cnt = 0;

  periph_subsys periph_subsys_i (
    .clk_i(clk_i), .rst_i(rst_i), .mem_valid_i(mem_valid_i), .mem_addr_i(mem_addr_i),
    .mem_wdata_i(mem_wdata_i), .mem_wstrb_i(mem_wstrb_i), .gpio_in_i(gpio_in_i),
    .irq_pin_i(irq_pin_i), .mem_ready_o(mem_ready_o), .mem_rdata_o(mem_rdata_o),
    .gpio_out_o(gpio_out_o), .gpio_oen_o(gpio_oen_o), .pwm_o(pwm_o), .irq_o(irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic check_eq(input string name, input soc_pkg::data_t exp,
                          input soc_pkg::data_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  // one nmi request, latency counted in cycles from the edge that sees valid
  task automatic bus_xfer(input soc_pkg::addr_t addr, input soc_pkg::strb_t wstrb,
                          input soc_pkg::data_t wdata, output soc_pkg::data_t rdata,
                          output int wait_cyc);
    @(negedge clk_i);
    mem_valid_i = 1'b1;
    mem_addr_i  = addr;
    mem_wstrb_i = wstrb;
    mem_wdata_i = wdata;
    wait_cyc    = 0;
    do begin
      @(negedge clk_i);
      wait_cyc++;
    end while (mem_ready_o !== 1'b1);
    rdata = mem_rdata_o;
    @(negedge clk_i);  // ready is taken at the rising edge in between
    mem_valid_i = 1'b0;
    mem_wstrb_i = '0;
  endtask

  task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t wdata);
    soc_pkg::data_t unused;
    int             unused_lat;
    bus_xfer(addr, 4'hF, wdata, unused, unused_lat);
  endtask

  task automatic bus_read(input soc_pkg::addr_t addr, output soc_pkg::data_t rdata);
    int unused_lat;
    bus_xfer(addr, 4'h0, '0, rdata, unused_lat);
  endtask

  // apb requests pass setup, access and done, native and unmapped ones answer in one cycle
  function automatic int exp_latency(input soc_pkg::addr_t addr);
    return (addr[31:28] == 4'h2) ? 3 : 1;
  endfunction

  function automatic soc_pkg::addr_t win_addr(input int i);
    return soc_pkg::RAM_BASE + soc_pkg::addr_t'((RAND_WORD0 + i) * 4);
  endfunction

  function automatic soc_pkg::data_t ram_pattern(input soc_pkg::addr_t addr);
    return {addr[15:0] ^ addr[31:16] ^ 16'hA5A5, ~addr[15:0]};
  endfunction

  task automatic fill_row(input int i, input string name, input soc_pkg::addr_t addr,
                          input soc_pkg::strb_t wstrb, input soc_pkg::data_t wdata,
                          input soc_pkg::data_t exp);
    tab_name[i]  = name;
    tab_addr[i]  = addr;
    tab_strb[i]  = wstrb;
    tab_wdata[i] = wdata;
    tab_exp[i]   = exp;
  endtask

  task automatic load_table;
    fill_row(0,  "ram_word0", soc_pkg::RAM_BASE + 32'h000, 4'hF, 32'hDEAD_BEEF, 32'hDEAD_BEEF);
    fill_row(1,  "ram_word255", soc_pkg::RAM_BASE + 32'h3FC, 4'hF, 32'h0123_4567,
             32'h0123_4567);
    fill_row(2,  "ram_low_half", soc_pkg::RAM_BASE, 4'h3, 32'h5555_AAAA, 32'hDEAD_AAAA);
    fill_row(3,  "gpio_out", soc_pkg::GPIO_BASE + soc_pkg::GPIO_OUT, 4'hF, 32'hA5, 32'hA5);
    fill_row(4,  "gpio_out_wide", soc_pkg::GPIO_BASE + soc_pkg::GPIO_OUT, 4'hF,
             32'hFFFF_FF5A, 32'h5A);  // only GPIO_W bits are kept
    fill_row(5,  "gpio_oen", soc_pkg::GPIO_BASE + soc_pkg::GPIO_OEN, 4'hF, 32'h3C, 32'h3C);
    fill_row(6,  "gpio_in_idle", soc_pkg::GPIO_BASE + soc_pkg::GPIO_IN, 4'h0, 32'h0, 32'h0);
    fill_row(7,  "tmr_cmp", soc_pkg::TIMER_BASE + soc_pkg::TMR_CMP, 4'hF, 32'h1234, 32'h1234);
    fill_row(8,  "tmr_count_idle", soc_pkg::TIMER_BASE + soc_pkg::TMR_COUNT, 4'h0, 32'h0,
             32'h0);
    fill_row(9,  "pwm_period", soc_pkg::APB_BASE + soc_pkg::PWM_PERIOD, 4'hF, 32'd100, 32'd100);
    fill_row(10, "pwm_duty", soc_pkg::APB_BASE + soc_pkg::PWM_DUTY, 4'hF, 32'd40, 32'd40);
    fill_row(11, "pwm_ctrl_idle", soc_pkg::APB_BASE + soc_pkg::PWM_CTRL, 4'h0, 32'h0, 32'h0);
    fill_row(12, "unmapped_read", 32'h3000_0000, 4'h0, 32'h0, 32'h0);
    fill_row(13, "unmapped_write", 32'h1000_2000, 4'hF, 32'hFFFF_FFFF, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    seed        = 32'h729c;
    err_cnt     = 0;
    chk_cnt     = 0;
    rst_i       = 1'b1;
    mem_valid_i = 1'b0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    gpio_in_i   = '0;
    irq_pin_i   = 1'b0;
    load_table();
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    // outputs idle after reset, the external pin feeds its bit directly
    check_eq("rst_mem_ready", 32'h0, mem_ready_o);
    check_eq("rst_gpio_oen", 32'h0, gpio_oen_o);
    check_eq("rst_gpio_out", 32'h0, gpio_out_o);
    check_eq("rst_pwm", 32'h0, pwm_o);
    check_eq("rst_irq", 32'h0, irq_o);
    irq_pin_i = 1'b1;
    #1 check_eq("irq_ext_high", 32'h1 << soc_pkg::IRQ_EXT, irq_o);
    @(negedge clk_i);
    irq_pin_i = 1'b0;
    #1 check_eq("irq_ext_low", 32'h0, irq_o);

    for (int i = 0; i < TAB_N; i++) begin
      if (tab_strb[i] != 4'h0) begin
        bus_xfer(tab_addr[i], tab_strb[i], tab_wdata[i], rd, lat);
        check_eq({tab_name[i], "_wr_lat"}, exp_latency(tab_addr[i]), lat);
      end
      bus_xfer(tab_addr[i], 4'h0, '0, rd, lat);
      check_eq(tab_name[i], tab_exp[i], rd);
      check_eq({tab_name[i], "_rd_lat"}, exp_latency(tab_addr[i]), lat);
      if (tab_addr[i] == soc_pkg::GPIO_BASE + soc_pkg::GPIO_OUT)
        check_eq({tab_name[i], "_pins"}, tab_exp[i], gpio_out_o);
      if (tab_addr[i] == soc_pkg::GPIO_BASE + soc_pkg::GPIO_OEN)
        check_eq({tab_name[i], "_pins"}, tab_exp[i], gpio_oen_o);
    end

    // known contents first, then partial-strobe writes against the model
    for (int i = 0; i < RAM_WIN; i++) begin
      ram_model[i] = ram_pattern(win_addr(i));
      bus_write(win_addr(i), ram_model[i]);
    end
    for (int n = 0; n < RAND_N; n++) begin
      w    = $random(seed) & (RAM_WIN - 1);
      strb = soc_pkg::strb_t'($random(seed));
      wd   = soc_pkg::data_t'($random(seed));
      if (strb == 4'h0 || strb == 4'hF)
        strb = 4'b0110;
      bus_xfer(win_addr(w), strb, wd, rd, lat);
      for (int b = 0; b < 4; b++)
        if (strb[b]) ram_model[w][8*b +: 8] = wd[8*b +: 8];
      bus_read(win_addr(w), rd);
      check_eq($sformatf("ram_rand_%0d", n), ram_model[w], rd);
    end

    // gpio rising edge on an enabled pin, then on a masked one
    bus_write(soc_pkg::GPIO_BASE + soc_pkg::GPIO_IEN, 32'h08);
    gpio_in_i[3] = 1'b1;
    k = 0;
    while (irq_o[soc_pkg::IRQ_GPIO] !== 1'b1 && k < 4) begin
      @(negedge clk_i);
      k++;
    end
    check_eq("gpio_irq_rise", 32'h1, irq_o[soc_pkg::IRQ_GPIO]);
    bus_read(soc_pkg::GPIO_BASE + soc_pkg::GPIO_IPEND, rd);
    check_eq("gpio_ipend", 32'h08, rd);
    bus_write(soc_pkg::GPIO_BASE + soc_pkg::GPIO_IPEND, 32'h08);
    check_eq("gpio_irq_clear", 32'h0, irq_o[soc_pkg::IRQ_GPIO]);
    gpio_in_i[5] = 1'b1;
    repeat (6) @(negedge clk_i);
    check_eq("gpio_irq_masked", 32'h0, irq_o[soc_pkg::IRQ_GPIO]);
    bus_read(soc_pkg::GPIO_BASE + soc_pkg::GPIO_IN, rd);
    check_eq("gpio_in_pins", 32'h28, rd);

    // timer match at a compare value of 20
    bus_write(soc_pkg::TIMER_BASE + soc_pkg::TMR_CMP, 32'd20);
    bus_write(soc_pkg::TIMER_BASE + soc_pkg::TMR_CTRL, 32'd1);
    k  = 0;
    rd = '0;
    while (rd != 32'd1 && k < 16) begin
      bus_read(soc_pkg::TIMER_BASE + soc_pkg::TMR_COUNT, cnt);
      if (cnt > 32'd20)
        check_eq("tmr_count_le_cmp", 32'd20, cnt);
      bus_read(soc_pkg::TIMER_BASE + soc_pkg::TMR_STAT, rd);
      k++;
    end
    check_eq("tmr_stat", 32'h1, rd);
    check_eq("tmr_irq_set", 32'h1, irq_o[soc_pkg::IRQ_TIMER]);
    bus_write(soc_pkg::TIMER_BASE + soc_pkg::TMR_CTRL, 32'd0);  // no further matches
    bus_write(soc_pkg::TIMER_BASE + soc_pkg::TMR_STAT, 32'd1);
    check_eq("tmr_irq_clear", 32'h0, irq_o[soc_pkg::IRQ_TIMER]);

    // pwm over three whole periods from the first high cycle
    bus_write(soc_pkg::APB_BASE + soc_pkg::PWM_PERIOD, PWM_PER);
    bus_write(soc_pkg::APB_BASE + soc_pkg::PWM_DUTY, PWM_DTY);
    bus_write(soc_pkg::APB_BASE + soc_pkg::PWM_CTRL, 32'd1);
    k = 0;
    while (pwm_o !== 1'b1 && k < 3 * PWM_PER) begin
      @(negedge clk_i);
      k++;
    end
    high_cnt = 0;
    repeat (3 * PWM_PER) begin
      if (pwm_o === 1'b1) high_cnt++;
      @(negedge clk_i);
    end
    check_eq("pwm_high_cycles", 3 * PWM_DTY, high_cnt);
    bus_write(soc_pkg::APB_BASE + soc_pkg::PWM_CTRL, 32'd0);
    high_cnt = 0;
    repeat (2 * PWM_PER) begin
      @(negedge clk_i);
      if (pwm_o !== 1'b0) high_cnt++;
    end
    check_eq("pwm_off", 32'h0, high_cnt);

    $display("%0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/soc_pkg.sv
rtl/nmi_bus.sv
rtl/natv_ram.sv
rtl/natv_gpio.sv
rtl/natv_timer.sv
rtl/apb_bridge.sv
rtl/apb_pwm.sv
rtl/periph_subsys.sv
test/tb_periph_subsys.sv
